//--- list.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/wallace_tree.sv
rtl/prefix_adder.sv
rtl/mul_wb_regs.sv
rtl/wallace_mul_top.sv
verification/tb_clock_gen.sv
verification/tb_wallace_mul.sv

//--- Bender.yml
package:
  name: wallace_mul

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mul_pkg.sv
      - rtl/wallace_tree.sv
      - rtl/prefix_adder.sv
      - rtl/mul_wb_regs.sv
      - rtl/wallace_mul_top.sv
      - target: test
        files:
          - verification/tb_clock_gen.sv
          - verification/tb_wallace_mul.sv

//--- verification/tb_wallace_mul.sv
// testbench for the bus-attached multiplier: bus tasks, model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module tb_wallace_mul;
    import mul_pkg::*;

    localparam realtime CLK_PERIOD = 40ns;
    localparam realtime DRIVE_DELAY = 2ns;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_SEED = 33879;
    localparam int RANDOM_PAIRS = 200;
    localparam int CORNER_PAIRS = 8;
    localparam int CYCLES_PER_ACCESS = 40;
    // reset reads, readback, random, corners, back-to-back, product writes
    localparam int TOTAL_ACCESSES = 4 + 8 + 4 * RANDOM_PAIRS + 4 * CORNER_PAIRS + 5 + 4;

    logic clk;
    logic reset;
    logic cyc;
    logic stb;
    logic we;
    wb_addr_t addr;
    wb_data_t wdata;
    wb_data_t rdata;
    logic ack;

    operand_t model_a;
    operand_t model_b;
    int checks;
    int errors;

    operand_t corner_a [CORNER_PAIRS] = '{32'h0, 32'h0, 32'h1, 32'h1,
        32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h1};
    operand_t corner_b [CORNER_PAIRS] = '{32'h0, 32'hffff_ffff, 32'h1, 32'hffff_ffff,
        32'hffff_ffff, 32'h8000_0000, 32'h1, 32'h8000_0000};

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    wallace_mul_top dut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack)
    );

    // unsigned product of the operands last written
    function automatic logic [63:0] model_product();
        return {32'b0, model_a} * {32'b0, model_b};
    endfunction

    // called and returns a drive delay after an edge
    task automatic wait_for_ack();
        do
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!ack);
    endtask

    task automatic bus_write(input wb_addr_t a, input wb_data_t d);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        addr = a;
        wdata = d;
        wait_for_ack();
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        if (a == `MUL_ADDR_OPERAND_A)
            model_a = d;
        if (a == `MUL_ADDR_OPERAND_B)
            model_b = d;
    endtask

    task automatic bus_read(input wb_addr_t a, output wb_data_t d);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        addr = a;
        wait_for_ack();
        d = rdata;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: expected 0x%016h, actual 0x%016h", name, expected, actual);
        end
    endtask

    // reads issued right away, so they land in the wait states
    task automatic check_product(input string name);
        wb_data_t lo;
        wb_data_t hi;
        bus_read(`MUL_ADDR_PRODUCT_LO, lo);
        bus_read(`MUL_ADDR_PRODUCT_HI, hi);
        check_value(name, model_product(), {hi, lo});
    endtask

    task automatic multiply_and_check(input string name, input operand_t a, input operand_t b);
        bus_write(`MUL_ADDR_OPERAND_A, a);
        bus_write(`MUL_ADDR_OPERAND_B, b);
        check_product(name);
    endtask

    initial
    begin
        #((TOTAL_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped acknowledging bus accesses");
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        wb_data_t word;
        operand_t a;
        operand_t b;

        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        model_a = '0;
        model_b = '0;
        checks = 0;
        errors = 0;
        void'($urandom(RANDOM_SEED));

        wait (reset == 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;

        for (int i = 0; i < 4; i++)
        begin
            bus_read(wb_addr_t'(i), word);
            check_value($sformatf("reset read addr %0d", i), 64'h0, {32'b0, word});
        end

        for (int i = 0; i < 2; i++)
        begin
            bus_write(`MUL_ADDR_OPERAND_A, $urandom());
            bus_write(`MUL_ADDR_OPERAND_B, $urandom());
            bus_read(`MUL_ADDR_OPERAND_A, word);
            check_value($sformatf("readback a %0d", i), {32'b0, model_a}, {32'b0, word});
            bus_read(`MUL_ADDR_OPERAND_B, word);
            check_value($sformatf("readback b %0d", i), {32'b0, model_b}, {32'b0, word});
        end

        for (int i = 0; i < RANDOM_PAIRS; i++)
        begin
            a = $urandom();
            b = $urandom();
            multiply_and_check($sformatf("random %0d", i), a, b);
        end

        for (int i = 0; i < CORNER_PAIRS; i++)
            multiply_and_check($sformatf("corner %0d", i), corner_a[i], corner_b[i]);

        // two products in flight
        bus_write(`MUL_ADDR_OPERAND_A, $urandom());
        bus_write(`MUL_ADDR_OPERAND_B, $urandom());
        bus_write(`MUL_ADDR_OPERAND_B, $urandom());
        check_product("back-to-back");

        bus_write(`MUL_ADDR_PRODUCT_LO, $urandom());
        bus_write(`MUL_ADDR_PRODUCT_HI, $urandom());
        check_product("product write ignored");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter realtime PERIOD = 40ns,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on an edge so the DUT samples it cleanly
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/wallace_mul_top.sv
// top level of the bus-attached multiplier: register slave, compressor tree and prefix adder
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module wallace_mul_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  mul_pkg::wb_addr_t addr,
    input  mul_pkg::wb_data_t wdata,
    output mul_pkg::wb_data_t rdata,
    output logic              ack
);
    import mul_pkg::*;

    operand_t operand_a;
    operand_t operand_b;
    product_t tree_sum;
    product_t tree_carry;
    product_t stage_sum;
    product_t stage_carry;
    product_t adder_sum;

    mul_wb_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .ack         (ack),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .tree_sum    (tree_sum),
        .tree_carry  (tree_carry),
        .stage_sum   (stage_sum),
        .stage_carry (stage_carry),
        .adder_sum   (adder_sum)
    );

    // first stage, combinational from the operand registers
    wallace_tree u_tree (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .sum_row   (tree_sum),
        .carry_row (tree_carry)
    );

    // second stage, from the tree stage register
    prefix_adder #(
        .WIDTH (`MUL_PRODUCT_WIDTH)
    ) u_adder (
        .a   (stage_sum),
        .b   (stage_carry),
        .sum (adder_sum)
    );

endmodule

`default_nettype wire

//--- rtl/mul_wb_regs.sv
// Wishbone classic register slave with operand, tree stage and product registers
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module mul_wb_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  mul_pkg::wb_addr_t addr,
    input  mul_pkg::wb_data_t wdata,
    output mul_pkg::wb_data_t rdata,
    output logic              ack,
    output mul_pkg::operand_t operand_a,
    output mul_pkg::operand_t operand_b,
    input  mul_pkg::product_t tree_sum,
    input  mul_pkg::product_t tree_carry,
    output mul_pkg::product_t stage_sum,
    output mul_pkg::product_t stage_carry,
    input  mul_pkg::product_t adder_sum
);
    import mul_pkg::*;

    logic request;
    logic product_read;
    logic accept;
    logic write_a;
    logic write_b;
    logic tree_valid;
    logic stage_valid;
    product_t product;
    wb_data_t read_word;

    // one ack per access, the ack cycle itself starts nothing
    assign request = cyc && stb && !ack;
    assign product_read = !we && (addr == `MUL_ADDR_PRODUCT_LO || addr == `MUL_ADDR_PRODUCT_HI);

    // hold product reads until the launched multiply lands
    assign accept = request && !(product_read && (tree_valid || stage_valid));

    assign write_a = accept && we && (addr == `MUL_ADDR_OPERAND_A);
    assign write_b = accept && we && (addr == `MUL_ADDR_OPERAND_B);

    always_comb
    begin
        case (addr)
            `MUL_ADDR_OPERAND_A: read_word = operand_a;
            `MUL_ADDR_OPERAND_B: read_word = operand_b;
            `MUL_ADDR_PRODUCT_LO: read_word = product[`WB_DATA_WIDTH-1:0];
            `MUL_ADDR_PRODUCT_HI: read_word = product[`MUL_PRODUCT_WIDTH-1:`WB_DATA_WIDTH];
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack <= 1'b0;
            operand_a <= '0;
            operand_b <= '0;
            tree_valid <= 1'b0;
        end
        else
        begin
            ack <= accept;
            // writing B launches a multiply
            tree_valid <= write_b;
            if (write_a)
                operand_a <= wdata;
            if (write_b)
                operand_b <= wdata;
        end
    end

    // pipeline flags and product
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_valid <= 1'b0;
            product <= '0;
        end
        else
        begin
            stage_valid <= tree_valid;
            if (stage_valid)
                product <= adder_sum;
        end
    end

    always_ff @(posedge clk)
    begin
        // tree rows one edge after the B write
        if (tree_valid)
        begin
            stage_sum <= tree_sum;
            stage_carry <= tree_carry;
        end
        if (accept)
            rdata <= read_word;
    end

endmodule

`default_nettype wire

//--- rtl/prefix_adder.sv
// recursive-doubling prefix adder over kill, propagate and generate classes
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module prefix_adder #(
    parameter int WIDTH = `MUL_PRODUCT_WIDTH
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum
);
    localparam int LEVELS = $clog2(WIDTH);

    // {a|b, a&b} per bit: 00 kill, 10 propagate, 11 generate
    logic [1:0] pgk [LEVELS+1][WIDTH];
    logic [WIDTH-2:0] carry;

    for (genvar i = 0; i < WIDTH; i++)
    begin : g_encode
        assign pgk[0][i] = {a[i] | b[i], a[i] & b[i]};
    end

    // span doubles every level: 1, 2, 4 ...
    for (genvar lvl = 0; lvl < LEVELS; lvl++)
    begin : g_level
        localparam int DIST = 1 << lvl;

        for (genvar i = 0; i < WIDTH; i++)
        begin : g_bit
            if (i >= DIST)
            begin : g_merge
                // propagate takes the class from below, kill and generate stay
                assign pgk[lvl+1][i] = {
                    pgk[lvl][i][0] | (pgk[lvl][i][1] & pgk[lvl][i-DIST][1]),
                    pgk[lvl][i][0] | (pgk[lvl][i][1] & pgk[lvl][i-DIST][0])
                };
            end
            else
            begin : g_pass
                assign pgk[lvl+1][i] = pgk[lvl][i];
            end
        end
    end

    // no carry in, so only a resolved generate carries
    for (genvar i = 0; i < WIDTH - 1; i++)
    begin : g_carry
        assign carry[i] = pgk[LEVELS][i][0];
    end

    // carry out of the top bit is dropped
    assign sum = a ^ b ^ {carry, 1'b0};

endmodule

`default_nettype wire

//--- rtl/wallace_tree.sv
// partial-product AND array and 3:2 carry-save compressor tree down to a sum and a carry row
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module wallace_tree (
    input  mul_pkg::operand_t operand_a,
    input  mul_pkg::operand_t operand_b,
    output mul_pkg::product_t sum_row,
    output mul_pkg::product_t carry_row
);
    import mul_pkg::*;

    localparam int ROWS = `MUL_ROW_COUNT;
    localparam int CSA_COUNT = ROWS - 1;

    // node numbers: partial rows first, then sum outputs, carry outputs, zero row
    localparam int S_BASE = ROWS;
    localparam int C_BASE = ROWS + CSA_COUNT;
    localparam int ZERO_NODE = ROWS + 2 * CSA_COUNT;
    localparam int NODE_COUNT = ZERO_NODE + 1;

    // inputs of each compressor row
    localparam int SCHEDULE [CSA_COUNT][3] = '{
        '{0, 1, 2},
        '{3, 4, 5},
        '{6, 7, 8},
        '{9, 10, 11},
        '{12, 13, 14},
        '{15, 16, 17},
        '{18, 19, 20},
        '{21, 22, 23},
        '{24, 25, 26},
        '{27, 28, 29},
        '{S_BASE + 0, C_BASE + 0, S_BASE + 1},
        '{C_BASE + 1, S_BASE + 2, C_BASE + 2},
        '{C_BASE + 3, S_BASE + 3, S_BASE + 4},
        '{C_BASE + 4, S_BASE + 5, C_BASE + 5},
        '{S_BASE + 6, C_BASE + 6, S_BASE + 7},
        '{C_BASE + 7, C_BASE + 8, S_BASE + 8},
        '{S_BASE + 9, C_BASE + 9, 30},
        '{S_BASE + 10, C_BASE + 10, S_BASE + 11},
        '{C_BASE + 11, S_BASE + 12, C_BASE + 12},
        '{C_BASE + 13, S_BASE + 13, S_BASE + 14},
        '{C_BASE + 14, C_BASE + 15, S_BASE + 15},
        '{S_BASE + 16, C_BASE + 16, 31},
        '{S_BASE + 17, C_BASE + 17, S_BASE + 18},
        '{C_BASE + 18, S_BASE + 19, C_BASE + 19},
        '{C_BASE + 20, S_BASE + 20, S_BASE + 21},
        '{S_BASE + 22, C_BASE + 22, S_BASE + 23},
        '{C_BASE + 23, S_BASE + 24, C_BASE + 24},
        '{C_BASE + 25, S_BASE + 25, S_BASE + 26},
        '{C_BASE + 26, C_BASE + 21, ZERO_NODE},
        '{S_BASE + 27, C_BASE + 27, S_BASE + 28},
        '{C_BASE + 28, S_BASE + 29, C_BASE + 29}
    };

    row_array_t partial_rows;
    product_t nodes [NODE_COUNT];

    // AND array, row i weighted by multiplier bit i
    for (genvar i = 0; i < ROWS; i++)
    begin : g_partial
        operand_t masked;

        assign masked = operand_a & {`MUL_OPERAND_WIDTH{operand_b[i]}};
        assign partial_rows[i] = product_t'(masked) << i;
        assign nodes[i] = partial_rows[i];
    end

    // pads the last odd compressor
    assign nodes[ZERO_NODE] = '0;

    for (genvar k = 0; k < CSA_COUNT; k++)
    begin : g_csa
        product_t x;
        product_t y;
        product_t z;

        assign x = nodes[SCHEDULE[k][0]];
        assign y = nodes[SCHEDULE[k][1]];
        assign z = nodes[SCHEDULE[k][2]];

        // full adder per column
        assign nodes[S_BASE + k] = x ^ y ^ z;
        // majority moves up one column, the top bit is beyond the product
        assign nodes[C_BASE + k] = ((x & y) | (x & z) | (y & z)) << 1;
    end

    assign sum_row = nodes[S_BASE + CSA_COUNT - 1];
    assign carry_row = nodes[C_BASE + CSA_COUNT - 1];

endmodule

`default_nettype wire

//--- rtl/mul_pkg.sv
// operand, product, partial-product row array and bus word types
`default_nettype none

`include "mul_macros.svh"

package mul_pkg;

    typedef logic [`MUL_OPERAND_WIDTH-1:0] operand_t;

    // also the width of every compressor row
    typedef logic [`MUL_PRODUCT_WIDTH-1:0] product_t;

    // shifted partial products, one per multiplier bit
    typedef product_t row_array_t [`MUL_ROW_COUNT];

    typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

    // word address, four registers
    typedef logic [1:0] wb_addr_t;

endpackage

`default_nettype wire

//--- rtl/mul_macros.svh
// operand and product widths, partial-product row count, bus width and register addresses
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// datapath
`define MUL_OPERAND_WIDTH 32
`define MUL_PRODUCT_WIDTH 64
`define MUL_ROW_COUNT 32

// bus data word
`define WB_DATA_WIDTH 32

// word addresses of the register slave
`define MUL_ADDR_OPERAND_A 2'd0
`define MUL_ADDR_OPERAND_B 2'd1
`define MUL_ADDR_PRODUCT_LO 2'd2
`define MUL_ADDR_PRODUCT_HI 2'd3

`endif
